/* src/sub_pkg.sv */
`default_nettype none

package sub_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Board geometry
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int BOARD_DIM    = 6;                        // Cells along each side of the board
    localparam int COORD_W      = 3;
    localparam int CELL_COUNT   = BOARD_DIM * BOARD_DIM;
    localparam int CELL_IDX_W   = 6;
    localparam int MAX_SHIP_LEN = 4;                        // Longest submarine in any preset map
    localparam int MAP_SEL_W    = 2;

    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [CELL_IDX_W-1:0] cell_idx_t;              // Flat index x * BOARD_DIM + y

    typedef enum logic [1:0] {
        DIR_LEFT,                                           // Toward x - 1
        DIR_RIGHT,                                          // Toward x + 1
        DIR_UP,                                             // Toward y + 1
        DIR_DOWN                                            // Toward y - 1
    } dir_t;

    function automatic cell_idx_t cell_index(coord_t cx, coord_t cy);
        return cell_idx_t'(cx * BOARD_DIM + cy);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Preset maps
    // ~~~~~~~~~~~~~~~~~~~~
    // Each group of six bits is one x value with x = 5 on the left.
    // Inside a group y = 5 is the leftmost bit. Ships are straight and
    // never share an edge with another ship
    localparam logic [CELL_COUNT-1:0] PRESET_MAPS [2**MAP_SEL_W] = '{
        36'b000011_100000_100000_100100_000000_001111,      // Ships of 4, 3, 2 and 1 cells
        36'b000010_010010_000010_000000_000110_000000,      // Ships of 3, 2 and 1 cells
        36'b101000_001000_000000_001111_000000_110000,      // Ships of 4, 2, 2 and 1 cells
        36'b000110_000000_100001_000001_011101_000001       // Ships of 4, 3, 2 and 1 cells
    };

endpackage

`default_nettype wire

/* src/board_mem.sv */
`default_nettype none

module board_mem import sub_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [MAP_SEL_W-1:0] init_select,
    input  logic                 select_valid,
    input  cell_idx_t            ctrl_idx,
    input  logic                 clear_en,
    input  cell_idx_t            trace_idx,
    input  logic                 trace_active,
    output logic                 preset_bit,
    output logic                 live_bit
);

    logic [CELL_COUNT-1:0] preset_plane;                    // Ship layout as loaded
    logic [CELL_COUNT-1:0] live_plane;                      // Cells not yet shot
    cell_idx_t             rd_idx;
    logic                  rd_in_range;
    logic                  clr_in_range;

    // ~~~~~~~~~~~~~~~~~~~~
    // Address select
    // ~~~~~~~~~~~~~~~~~~~~
    assign rd_idx       = trace_active ? trace_idx : ctrl_idx;  // Tracer owns the port while walking
    assign rd_in_range  = (rd_idx < CELL_COUNT);
    assign clr_in_range = (ctrl_idx < CELL_COUNT);

    // ~~~~~~~~~~~~~~~~~~~~
    // Plane update
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            preset_plane <= '0;                             // Empty board until a map is chosen
            live_plane   <= '0;
        end else if (select_valid) begin
            preset_plane <= PRESET_MAPS[init_select];
            live_plane   <= PRESET_MAPS[init_select];
        end else if (clear_en && clr_in_range) begin
            live_plane[ctrl_idx] <= 1'b0;                   // Shot cell is gone from the next edge on
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Registered read
    // ~~~~~~~~~~~~~~~~~~~~
    // Both planes are sampled at the same address so the tracer sees
    // the layout and the damage of one cell together
    always_ff @(posedge clk) begin
        preset_bit <= rd_in_range && preset_plane[rd_idx];
        live_bit   <= rd_in_range && live_plane[rd_idx];
    end

endmodule

`default_nettype wire

/* src/shot_ctrl.sv */
`default_nettype none

module shot_ctrl import sub_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  coord_t    x,
    input  coord_t    y,
    input  logic      cord_valid,
    input  logic      select_valid,
    input  logic      live_bit,
    input  logic      trace_done,
    input  logic      ship_alive,
    output cell_idx_t ctrl_idx,
    output logic      clear_en,
    output logic      trace_start,
    output cell_idx_t shot_idx,
    output logic      busy,
    output logic      hit,
    output logic      sink,
    output logic      done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CLEAR,
        ST_TRACE,
        ST_SCAN,
        ST_END
    } state_t;

    state_t state;
    logic   in_range;
    logic   scan_primed;                                    // Read data in live_bit is for ctrl_idx - 1

    assign in_range = (x < BOARD_DIM) && (y < BOARD_DIM);
    assign busy     = (state != ST_IDLE);
    assign shot_idx = ctrl_idx;                             // Still the shot cell when the walk starts

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= ST_IDLE;
            ctrl_idx    <= '0;
            clear_en    <= 1'b0;
            trace_start <= 1'b0;
            scan_primed <= 1'b0;
            hit         <= 1'b0;
            sink        <= 1'b0;
            done        <= 1'b0;
        end else begin
            clear_en    <= 1'b0;                            // Strobes and pulses last one cycle
            trace_start <= 1'b0;
            hit         <= 1'b0;
            sink        <= 1'b0;
            if (select_valid) begin
                state       <= ST_IDLE;                     // A new map abandons the current shot
                scan_primed <= 1'b0;
                done        <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (cord_valid && in_range) begin
                            ctrl_idx <= cell_index(x, y);
                            state    <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        state <= ST_CLEAR;                  // Board registers the cell on this edge
                    end
                    ST_CLEAR: begin
                        if (live_bit) begin
                            clear_en    <= 1'b1;
                            trace_start <= 1'b1;
                            state       <= ST_TRACE;
                        end else begin
                            state <= ST_IDLE;               // Miss or repeated shot
                        end
                    end
                    ST_TRACE: begin
                        if (trace_done && ship_alive) begin
                            hit   <= 1'b1;
                            state <= ST_IDLE;
                        end else if (trace_done) begin
                            ctrl_idx    <= '0;              // Ship is gone so look at the whole board
                            scan_primed <= 1'b0;
                            state       <= ST_SCAN;
                        end
                    end
                    ST_SCAN: begin
                        // Addresses run one ahead of the data
                        if (scan_primed && live_bit) begin
                            sink  <= 1'b1;
                            state <= ST_IDLE;
                        end else if (ctrl_idx == cell_idx_t'(CELL_COUNT)) begin
                            done  <= 1'b1;                  // Last cell came back empty
                            state <= ST_END;
                        end else begin
                            ctrl_idx    <= ctrl_idx + 1'b1;
                            scan_primed <= 1'b1;
                        end
                    end
                    ST_END: begin
                        state <= ST_END;                    // Held until the next map load
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/sink_tracer.sv */
`default_nettype none

module sink_tracer import sub_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      trace_start,
    input  cell_idx_t shot_idx,
    input  logic      preset_bit,
    input  logic      live_bit,
    output cell_idx_t trace_idx,
    output logic      trace_active,
    output logic      trace_done,
    output logic      ship_alive
);

    typedef enum logic [1:0] {
        TR_IDLE,
        TR_STEP,
        TR_WAIT
    } tr_state_t;

    tr_state_t  state;
    dir_t       dir;
    logic [1:0] step_cnt;                                   // Steps taken in the current direction
    logic       have_data;                                  // Board bits belong to cur_x and cur_y
    coord_t     start_x;
    coord_t     start_y;
    coord_t     org_x;
    coord_t     org_y;
    coord_t     cur_x;
    coord_t     cur_y;
    coord_t     nbr_x;
    coord_t     nbr_y;
    logic       at_edge;
    logic       found_live;
    logic       step_go;

    assign start_x      = coord_t'(shot_idx / BOARD_DIM);
    assign start_y      = coord_t'(shot_idx % BOARD_DIM);
    assign trace_idx    = cell_index(cur_x, cur_y);
    assign trace_active = (state != TR_IDLE);

    // ~~~~~~~~~~~~~~~~~~~~
    // Neighbor and stop logic
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        nbr_x   = cur_x;
        nbr_y   = cur_y;
        at_edge = 1'b0;
        case (dir)
            DIR_LEFT: begin
                at_edge = (cur_x == '0);
                nbr_x   = cur_x - 1'b1;
            end
            DIR_RIGHT: begin
                at_edge = (cur_x == coord_t'(BOARD_DIM - 1));
                nbr_x   = cur_x + 1'b1;
            end
            DIR_UP: begin
                at_edge = (cur_y == coord_t'(BOARD_DIM - 1));
                nbr_y   = cur_y + 1'b1;
            end
            default: begin
                at_edge = (cur_y == '0);
                nbr_y   = cur_y - 1'b1;
            end
        endcase
    end

    // A run continues only through preset cells and stops short of the longest ship
    assign found_live = have_data && live_bit;
    assign step_go    = !found_live && (!have_data || preset_bit) && !at_edge &&
                        (step_cnt != 2'(MAX_SHIP_LEN - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // Walk FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= TR_IDLE;
            dir        <= DIR_LEFT;
            step_cnt   <= '0;
            have_data  <= 1'b0;
            trace_done <= 1'b0;
            ship_alive <= 1'b0;
        end else begin
            trace_done <= 1'b0;
            case (state)
                TR_IDLE: begin
                    if (trace_start) begin
                        dir       <= DIR_LEFT;
                        step_cnt  <= '0;
                        have_data <= 1'b0;
                        state     <= TR_STEP;
                    end
                end
                TR_WAIT: begin
                    have_data <= 1'b1;                      // Read of the new cell lands on this edge
                    state     <= TR_STEP;
                end
                TR_STEP: begin
                    if (found_live) begin
                        trace_done <= 1'b1;                 // One live cell is enough
                        ship_alive <= 1'b1;
                        state      <= TR_IDLE;
                    end else if (step_go) begin
                        step_cnt <= step_cnt + 1'b1;
                        state    <= TR_WAIT;
                    end else if (dir == DIR_DOWN) begin
                        trace_done <= 1'b1;
                        ship_alive <= 1'b0;
                        state      <= TR_IDLE;
                    end else begin
                        dir       <= dir_t'(dir + 1'b1);
                        step_cnt  <= '0;
                        have_data <= 1'b0;
                    end
                end
                default: begin
                    state <= TR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TR_IDLE && trace_start) begin
            org_x <= start_x;
            org_y <= start_y;
            cur_x <= start_x;
            cur_y <= start_y;
        end else if (state == TR_STEP && step_go) begin
            cur_x <= nbr_x;
            cur_y <= nbr_y;
        end else if (state == TR_STEP && !found_live) begin
            cur_x <= org_x;                                 // Next direction starts from the shot cell
            cur_y <= org_y;
        end
    end

endmodule

`default_nettype wire

/* src/submarine_top.sv */
`default_nettype none

module submarine_top import sub_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [MAP_SEL_W-1:0] init_select,
    input  logic                 select_valid,
    input  coord_t               x,
    input  coord_t               y,
    input  logic                 cord_valid,
    output logic                 busy,
    output logic                 hit,
    output logic                 sink,
    output logic                 done
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Internal nets
    // ~~~~~~~~~~~~~~~~~~~~
    cell_idx_t ctrl_idx;
    logic      clear_en;
    cell_idx_t trace_idx;
    logic      trace_active;
    logic      preset_bit;
    logic      live_bit;
    logic      trace_start;
    cell_idx_t shot_idx;
    logic      trace_done;
    logic      ship_alive;

    shot_ctrl u_shot_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .x            (x),
        .y            (y),
        .cord_valid   (cord_valid),
        .select_valid (select_valid),
        .live_bit     (live_bit),
        .trace_done   (trace_done),
        .ship_alive   (ship_alive),
        .ctrl_idx     (ctrl_idx),
        .clear_en     (clear_en),
        .trace_start  (trace_start),
        .shot_idx     (shot_idx),
        .busy         (busy),
        .hit          (hit),
        .sink         (sink),
        .done         (done)
    );

    board_mem u_board_mem (
        .clk          (clk),
        .rstn         (rstn),
        .init_select  (init_select),
        .select_valid (select_valid),
        .ctrl_idx     (ctrl_idx),
        .clear_en     (clear_en),
        .trace_idx    (trace_idx),
        .trace_active (trace_active),
        .preset_bit   (preset_bit),
        .live_bit     (live_bit)
    );

    sink_tracer u_sink_tracer (
        .clk          (clk),
        .rstn         (rstn),
        .trace_start  (trace_start),
        .shot_idx     (shot_idx),
        .preset_bit   (preset_bit),
        .live_bit     (live_bit),
        .trace_idx    (trace_idx),
        .trace_active (trace_active),
        .trace_done   (trace_done),
        .ship_alive   (ship_alive)
    );

endmodule

`default_nettype wire

/* verif/submarine_chk.sv */
`default_nettype none

module submarine_chk (
    input logic clk,
    input logic rstn,
    input logic select_valid,
    input logic busy,
    input logic hit,
    input logic sink,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // Result pulses
    // ~~~~~~~~~~~~~~~~~~~~
    hit_sink_apart: assert property (@(posedge clk) disable iff (!rstn) !(hit && sink))
        else $error("hit and sink are high in the same cycle");

    hit_one_cycle: assert property (@(posedge clk) disable iff (!rstn) hit |=> !hit)
        else $error("hit stayed high for more than one cycle");

    sink_one_cycle: assert property (@(posedge clk) disable iff (!rstn) sink |=> !sink)
        else $error("sink stayed high for more than one cycle");

    // The result cycle is also the first idle cycle
    pulse_not_busy: assert property (@(posedge clk) disable iff (!rstn) (hit || sink) |-> !busy)
        else $error("busy is high in a cycle with a hit or sink pulse");

    // ~~~~~~~~~~~~~~~~~~~~
    // End of game
    // ~~~~~~~~~~~~~~~~~~~~
    done_held: assert property (@(posedge clk) disable iff (!rstn)
                                (done && !select_valid) |=> done)
        else $error("done fell without a map load");

endmodule

`default_nettype wire

/* verif/submarine_tb.sv */
`default_nettype none

module submarine_tb import sub_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD       = 8;
    localparam int ROW_LIMIT        = 150;                  // Cycles one row may keep busy high
    localparam int WATCHDOG_PER_ROW = 200;

    typedef enum logic [1:0] {
        OUT_MISS,                                           // No pulse and busy back low
        OUT_HIT,
        OUT_SINK,
        OUT_DONE
    } outcome_t;

    typedef struct packed {
        logic                 is_select;
        logic [MAP_SEL_W-1:0] map;
        coord_t               sx;
        coord_t               sy;
        outcome_t             want;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic [MAP_SEL_W-1:0]  init_select;
    logic                  select_valid;
    coord_t                x;
    coord_t                y;
    logic                  cord_valid;
    logic                  busy;
    logic                  hit;
    logic                  sink;
    logic                  done;

    row_t                  rows[$];
    logic [CELL_COUNT-1:0] model_preset;                    // Reference copy of the loaded map
    logic [CELL_COUNT-1:0] model_live;
    int                    errors;
    int                    passed;
    integer                seed;
    logic                  table_ready;

    submarine_top u_submarine_top (
        .clk          (clk),
        .rstn         (rstn),
        .init_select  (init_select),
        .select_valid (select_valid),
        .x            (x),
        .y            (y),
        .cord_valid   (cord_valid),
        .busy         (busy),
        .hit          (hit),
        .sink         (sink),
        .done         (done)
    );

    bind submarine_top submarine_chk u_submarine_chk (
        .clk          (clk),
        .rstn         (rstn),
        .select_valid (select_valid),
        .busy         (busy),
        .hit          (hit),
        .sink         (sink),
        .done         (done)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic string outcome_name(input outcome_t o);
        case (o)
            OUT_HIT:  return "hit";
            OUT_SINK: return "sink";
            OUT_DONE: return "done";
            default:  return "miss";
        endcase
    endfunction

    // A ship is the straight run of preset cells through the shot cell
    function automatic outcome_t predict_shot(input int sx, input int sy);
        int   dx[4] = '{-1, 1, 0, 0};
        int   dy[4] = '{0, 0, 1, -1};
        int   cx;
        int   cy;
        int   d;
        logic alive;
        alive = 1'b0;
        if (sx >= BOARD_DIM || sy >= BOARD_DIM) return OUT_MISS;
        if (!model_live[sx * BOARD_DIM + sy]) return OUT_MISS;
        model_live[sx * BOARD_DIM + sy] = 1'b0;
        for (d = 0; d < 4; d++) begin
            cx = sx + dx[d];
            cy = sy + dy[d];
            while (cx >= 0 && cx < BOARD_DIM && cy >= 0 && cy < BOARD_DIM &&
                   model_preset[cx * BOARD_DIM + cy]) begin
                alive = alive | model_live[cx * BOARD_DIM + cy];
                cx    = cx + dx[d];
                cy    = cy + dy[d];
            end
        end
        if (alive) return OUT_HIT;
        if (model_live == '0) return OUT_DONE;
        return OUT_SINK;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic add_row(input logic is_sel, input int a, input int b, input outcome_t want);
        row_t r;
        r.is_select = is_sel;
        r.map       = MAP_SEL_W'(a);
        r.sx        = coord_t'(a);
        r.sy        = coord_t'(b);
        r.want      = want;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int cells[$];
        int i;
        int j;
        int tmp;
        outcome_t want;
        // Empty board after reset
        add_row(1'b0, 0, 0, OUT_MISS);
        add_row(1'b0, 3, 5, OUT_MISS);
        add_row(1'b0, 5, 5, OUT_MISS);
        // Map 0 with water and off-board shots
        add_row(1'b1, 0, 0, OUT_MISS);
        add_row(1'b0, 1, 0, OUT_MISS);
        add_row(1'b0, 3, 3, OUT_MISS);
        add_row(1'b0, 6, 0, OUT_MISS);
        add_row(1'b0, 0, 7, OUT_MISS);
        add_row(1'b0, 7, 7, OUT_MISS);
        // Two ships of map 0 sunk cell by cell, then repeated shots
        add_row(1'b0, 2, 5, OUT_HIT);
        add_row(1'b0, 3, 5, OUT_HIT);
        add_row(1'b0, 4, 5, OUT_SINK);
        add_row(1'b0, 3, 5, OUT_MISS);
        add_row(1'b0, 0, 1, OUT_HIT);
        add_row(1'b0, 0, 3, OUT_HIT);
        add_row(1'b0, 0, 0, OUT_HIT);
        add_row(1'b0, 0, 2, OUT_SINK);
        add_row(1'b0, 0, 2, OUT_MISS);
        // Map 1 cleared to the end of the game
        add_row(1'b1, 1, 0, OUT_MISS);
        add_row(1'b0, 4, 4, OUT_SINK);
        add_row(1'b0, 1, 1, OUT_HIT);
        add_row(1'b0, 1, 2, OUT_SINK);
        add_row(1'b0, 3, 1, OUT_HIT);
        add_row(1'b0, 5, 1, OUT_HIT);
        add_row(1'b0, 4, 1, OUT_DONE);
        add_row(1'b0, 2, 2, OUT_DONE);                      // Ignored while done holds
        add_row(1'b1, 1, 0, OUT_MISS);                      // Reload drops done
        // Map 3 in a shuffled order
        add_row(1'b1, 3, 0, OUT_MISS);
        model_preset = PRESET_MAPS[3];
        model_live   = PRESET_MAPS[3];
        for (i = 0; i < CELL_COUNT; i++) begin
            if (model_preset[i]) cells.push_back(i);
        end
        for (i = cells.size() - 1; i > 0; i--) begin
            j        = int'($unsigned($random(seed)) % (i + 1));
            tmp      = cells[i];
            cells[i] = cells[j];
            cells[j] = tmp;
        end
        for (i = 0; i < cells.size(); i++) begin
            want = predict_shot(cells[i] / BOARD_DIM, cells[i] % BOARD_DIM);
            add_row(1'b0, cells[i] / BOARD_DIM, cells[i] % BOARD_DIM, want);
        end
        // Map 2 reloaded in the middle of a game
        add_row(1'b1, 2, 0, OUT_MISS);
        add_row(1'b0, 2, 0, OUT_HIT);
        add_row(1'b0, 2, 1, OUT_HIT);
        add_row(1'b0, 4, 3, OUT_HIT);
        add_row(1'b1, 2, 0, OUT_MISS);
        add_row(1'b0, 2, 0, OUT_HIT);                       // Live again after the reload
        add_row(1'b0, 4, 3, OUT_HIT);
        add_row(1'b0, 5, 3, OUT_SINK);
        add_row(1'b0, 5, 5, OUT_SINK);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Row execution
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic apply_row(input int n);
        row_t     r;
        int       cycles;
        int       hit_cnt;
        int       sink_cnt;
        int       busy_want;
        logic     done_seen;
        logic     stop;
        logic     ok;
        outcome_t got;
        string    what;
        r         = rows[n];
        cycles    = 0;
        hit_cnt   = 0;
        sink_cnt  = 0;
        done_seen = 1'b0;
        stop      = 1'b0;
        ok        = 1'b1;
        if (r.is_select) begin
            init_select  = r.map;
            select_valid = 1'b1;
            what         = $sformatf("select map %0d", r.map);
        end else begin
            x          = r.sx;
            y          = r.sy;
            cord_valid = 1'b1;
            what       = $sformatf("shot (%0d,%0d)", r.sx, r.sy);
        end
        @(negedge clk);
        select_valid = 1'b0;
        cord_valid   = 1'b0;
        while (!stop) begin
            if (hit) hit_cnt++;
            if (sink) sink_cnt++;
            done_seen = done;
            if (done || !busy || cycles >= ROW_LIMIT) begin
                stop = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        assert (cycles < ROW_LIMIT) else begin
            $display("Row %0d never finished, busy stayed high for %0d cycles", n, cycles);
            ok = 1'b0;
        end
        assert (hit_cnt + sink_cnt + int'(done_seen) <= 1) else begin
            $display("MISMATCH at %0t: row %0d saw %0d hit, %0d sink pulses, done %0b",
                     $time, n, hit_cnt, sink_cnt, done_seen);
            ok = 1'b0;
        end
        got = done_seen ? OUT_DONE : (sink_cnt > 0) ? OUT_SINK :
              (hit_cnt > 0) ? OUT_HIT : OUT_MISS;
        assert (got == r.want) else begin
            $display("MISMATCH at %0t: row %0d %s expected %s but got %s",
                     $time, n, what, outcome_name(r.want), outcome_name(got));
            ok = 1'b0;
        end
        if (r.want == OUT_MISS) begin
            // An accepted miss holds busy for the read and the check of the cell
            busy_want = (!r.is_select && r.sx < BOARD_DIM && r.sy < BOARD_DIM) ? 2 : 0;
            assert (cycles == busy_want) else begin
                $display("MISMATCH at %0t: row %0d %s held busy for %0d cycles, expected %0d",
                         $time, n, what, cycles, busy_want);
                ok = 1'b0;
            end
        end
        if (ok) passed++;
        else errors++;
        $display("Row %0d %s: expected %s, got %s, %s",
                 n, what, outcome_name(r.want), outcome_name(got), ok ? "pass" : "fail");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock, sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        int i;
        rstn         = 1'b0;
        init_select  = '0;
        select_valid = 1'b0;
        x            = '0;
        y            = '0;
        cord_valid   = 1'b0;
        errors       = 0;
        passed       = 0;
        seed         = 35;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("Rows run: %0d, passed: %0d, failed: %0d", rows.size(), passed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * WATCHDOG_PER_ROW + 8) @(posedge clk);   // Margin covers reset
        $display("Watchdog timeout, the table did not finish in the allowed time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/sub_pkg.sv
src/board_mem.sv
src/shot_ctrl.sv
src/sink_tracer.sv
src/submarine_top.sv
verif/submarine_chk.sv
verif/submarine_tb.sv

/* Makefile */
TOP := submarine_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
